// ==== logic/vga_mem_pkg.sv ====
// VGA planar memory path, shared definitions
// Widths, graphics-controller register indices, field positions
// and write mode codes for the whole memory path
`default_nettype none

package vga_mem_pkg;

  // Bus widths
  localparam int SRAM_AW = 17;  // SRAM word address, plane in bits 1:0
  localparam int CPU_AW  = 16;  // CPU word address
  localparam int DW      = 16;
  localparam int NPLANES = 4;

  // Graphics-controller register indices
  localparam logic [3:0] GR_SET_RESET    = 4'd0;
  localparam logic [3:0] GR_EN_SET_RESET = 4'd1;
  localparam logic [3:0] GR_COLOR_CMP    = 4'd2;
  localparam logic [3:0] GR_READ_MAP     = 4'd4;
  localparam logic [3:0] GR_MODE         = 4'd5;
  localparam logic [3:0] GR_MISC         = 4'd6;
  localparam logic [3:0] GR_DONT_CARE    = 4'd7;
  localparam logic [3:0] GR_BIT_MASK     = 4'd8;

  // Mode register fields
  localparam int WMODE_LSB = 0;  // two write mode bits
  localparam int RMODE_BIT = 3;

  // Misc register, memory mapping bit
  localparam int MISC_MAP_BIT = 2;

  // Write mode codes, mode 3 behaves as mode 0
  localparam logic [1:0] WM_SETRESET = 2'd0;
  localparam logic [1:0] WM_LATCH    = 2'd1;
  localparam logic [1:0] WM_COLOR    = 2'd2;

endpackage

`default_nettype wire

// ==== logic/vga_mem_ifs.sv ====
// VGA planar memory path, internal bundles
// vga_cfg_if carries the decoded graphics-controller fields as levels,
// vga_sram_if carries one engine's word request towards the SRAM master
`timescale 1ns/1ns
`default_nettype none

interface vga_cfg_if import vga_mem_pkg::*; ();
  logic [NPLANES-1:0] set_reset;
  logic [NPLANES-1:0] en_set_reset;
  logic [NPLANES-1:0] color_compare;
  logic [NPLANES-1:0] color_dont_care;
  logic [1:0]         read_map_select;
  logic               read_mode;
  logic [1:0]         write_mode;
  logic               memory_mapping1;
  logic [7:0]         bit_mask;

  // Register file drives everything
  modport regs (output set_reset, en_set_reset, color_compare, color_dont_care,
                read_map_select, read_mode, write_mode, memory_mapping1, bit_mask);

  // Read engine, compare and plane select only
  modport rd (input color_compare, color_dont_care, read_map_select, read_mode,
              memory_mapping1);

  // Write engine, data forming fields
  modport wr (input set_reset, en_set_reset, write_mode, memory_mapping1, bit_mask);
endinterface

interface vga_sram_if import vga_mem_pkg::*; ();
  logic [SRAM_AW:1] adr;
  logic [DW-1:0]    dat_w;
  logic [1:0]       sel;
  logic             we;
  logic             stb;    // level, held until ack
  logic [DW-1:0]    dat_r;
  logic             ack;    // one word done

  modport master (output adr, dat_w, sel, we, stb, input dat_r, ack);
  modport slave  (input adr, dat_w, sel, we, stb, output dat_r, ack);
endinterface

`default_nettype wire

// ==== logic/vga_gfx_regs.sv ====
// VGA graphics-controller register file
// Takes single-cycle index writes from the config port and presents
// the decoded fields as levels. Also splits the CPU strobe into a
// read or a write request, fixed for the length of the access
`timescale 1ns/1ns
`default_nettype none

module vga_gfx_regs import vga_mem_pkg::*; (
  input  wire        wb_clk_i,
  input  wire        wb_rst_i,

  // Config write port
  input  wire        cfg_we_i,
  input  wire  [3:0] cfg_idx_i,
  input  wire  [7:0] cfg_dat_i,

  // CPU strobe split
  input  wire        wbs_stb_i,
  input  wire        wbs_we_i,
  output logic       rd_stb_o,
  output logic       wr_stb_o,

  vga_cfg_if.regs    cfg
);

  logic [NPLANES-1:0] set_reset_q;
  logic [NPLANES-1:0] en_set_reset_q;
  logic [NPLANES-1:0] color_cmp_q;
  logic [NPLANES-1:0] dont_care_q;
  logic [1:0]         read_map_q;
  logic [1:0]         write_mode_q;
  logic               read_mode_q;
  logic               map1_q;
  logic [7:0]         bit_mask_q;

  // Index register writes, visible after the next edge
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      set_reset_q    <= '0;
      en_set_reset_q <= '0;
      color_cmp_q    <= '0;
      dont_care_q    <= '0;
      read_map_q     <= '0;
      write_mode_q   <= '0;
      read_mode_q    <= 1'b0;
      map1_q         <= 1'b0;
      bit_mask_q     <= '0;
    end
    else if (cfg_we_i)
    begin
      case (cfg_idx_i)
        GR_SET_RESET:    set_reset_q    <= cfg_dat_i[NPLANES-1:0];
        GR_EN_SET_RESET: en_set_reset_q <= cfg_dat_i[NPLANES-1:0];
        GR_COLOR_CMP:    color_cmp_q    <= cfg_dat_i[NPLANES-1:0];
        GR_READ_MAP:     read_map_q     <= cfg_dat_i[1:0];
        GR_MODE:
        begin
          write_mode_q <= cfg_dat_i[WMODE_LSB +: 2];
          read_mode_q  <= cfg_dat_i[RMODE_BIT];
        end
        GR_MISC:         map1_q         <= cfg_dat_i[MISC_MAP_BIT];
        GR_DONT_CARE:    dont_care_q    <= cfg_dat_i[NPLANES-1:0];
        GR_BIT_MASK:     bit_mask_q     <= cfg_dat_i;
        default:         ;
      endcase
    end
  end

  // Decoded fields out as levels
  assign cfg.set_reset       = set_reset_q;
  assign cfg.en_set_reset    = en_set_reset_q;
  assign cfg.color_compare   = color_cmp_q;
  assign cfg.color_dont_care = dont_care_q;
  assign cfg.read_map_select = read_map_q;
  assign cfg.write_mode      = write_mode_q;
  assign cfg.read_mode       = read_mode_q;
  assign cfg.memory_mapping1 = map1_q;
  assign cfg.bit_mask        = bit_mask_q;

  // Direction captured when the strobe rises, held until it falls
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i || !wbs_stb_i)
    begin
      rd_stb_o <= 1'b0;
      wr_stb_o <= 1'b0;
    end
    else if (!rd_stb_o && !wr_stb_o)
    begin
      rd_stb_o <= ~wbs_we_i;
      wr_stb_o <= wbs_we_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/vga_read_iface.sv ====
// VGA read engine
// One CPU read fetches planes 0 to 3 in order and loads the four latches.
// Read mode 0 returns the selected plane, read mode 1 the colour-compare
// result. The latch byte outputs feed the write engine
`timescale 1ns/1ns
`default_nettype none

module vga_read_iface import vga_mem_pkg::*; (
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,

  // CPU side
  input  wire   [CPU_AW:1]   wbs_adr_i,
  input  wire   [1:0]        wbs_sel_i,
  input  wire                rd_stb_i,
  output logic  [DW-1:0]     rd_dat_o,
  output logic               rd_ack_o,

  // Latch bytes for write mode 1 and the bit mask path
  output logic  [7:0]        latch0_o,
  output logic  [7:0]        latch1_o,
  output logic  [7:0]        latch2_o,
  output logic  [7:0]        latch3_o,

  vga_cfg_if.rd              cfg,
  vga_sram_if.master         mem
);

  logic [1:0]        plane;
  logic              latch_sel;
  logic              done;
  logic [DW-1:0]     latch [NPLANES];
  logic [CPU_AW-1:1] offset;
  logic              start;
  logic              last_ack;
  logic [DW-1:0]     dat_mode0;
  logic [DW-1:0]     cmp_or;
  logic [DW-1:0]     plane_word;

  // Mapping1 folds the upper half onto the lower
  assign offset = cfg.memory_mapping1 ? {1'b0, wbs_adr_i[CPU_AW-2:1]}
                                      : wbs_adr_i[CPU_AW-1:1];

  assign mem.adr   = {offset, plane};
  assign mem.dat_w = '0;
  assign mem.sel   = wbs_sel_i;
  assign mem.we    = 1'b0;

  // New access only once the previous strobe has gone away
  assign start    = rd_stb_i && !mem.stb && !done;
  assign last_ack = mem.ack && mem.stb && (plane == 2'd3);
  assign rd_ack_o = last_ack;

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      mem.stb   <= 1'b0;
      done      <= 1'b0;
      plane     <= 2'd0;
      latch_sel <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        mem.stb   <= 1'b1;
        latch_sel <= wbs_sel_i[1];
      end
      else if (last_ack)
        mem.stb <= 1'b0;

      // Blocks a second pass while the CPU strobe is still seen high
      if (last_ack)
        done <= 1'b1;
      else if (!rd_stb_i)
        done <= 1'b0;

      // Steps per word, wraps back to 0 after plane 3
      if (mem.ack && mem.stb)
        plane <= plane + 2'd1;
    end
  end

  // Latch load, one plane per ack
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      for (int p = 0; p < NPLANES; p++)
        latch[p] <= '0;
    end
    else if (mem.ack && mem.stb)
      latch[plane] <= mem.dat_r;
  end

  // Byte lane of the last read
  assign latch0_o = latch_sel ? latch[0][15:8] : latch[0][7:0];
  assign latch1_o = latch_sel ? latch[1][15:8] : latch[1][7:0];
  assign latch2_o = latch_sel ? latch[2][15:8] : latch[2][7:0];
  assign latch3_o = latch_sel ? latch[3][15:8] : latch[3][7:0];

  // Mode 0, plane 3 is not latched yet so take it live
  assign dat_mode0 = (cfg.read_map_select == 2'd3) ? mem.dat_r
                                                   : latch[cfg.read_map_select];

  // Mode 1, OR of masked differences, plane 3 live
  always_comb
  begin
    cmp_or     = '0;
    plane_word = '0;
    for (int p = 0; p < NPLANES; p++)
    begin
      plane_word = (p == NPLANES - 1) ? mem.dat_r : latch[p];
      cmp_or = cmp_or | ((plane_word ^ {DW{cfg.color_compare[p]}})
                         & {DW{cfg.color_dont_care[p]}});
    end
  end

  assign rd_dat_o = cfg.read_mode ? ~cmp_or : dat_mode0;

endmodule

`default_nettype wire

// ==== logic/vga_write_iface.sv ====
// VGA write engine
// One CPU write stores a word into each of the four planes. The word per
// plane comes from the write mode: set/reset with bit mask, latch copy,
// or colour expansion with bit mask. Mode 3 is handled as mode 0
`timescale 1ns/1ns
`default_nettype none

module vga_write_iface import vga_mem_pkg::*; (
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,

  // CPU side
  input  wire   [CPU_AW:1]   wbs_adr_i,
  input  wire   [1:0]        wbs_sel_i,
  input  wire   [DW-1:0]     wbs_dat_i,
  input  wire                wr_stb_i,
  output logic               wr_ack_o,

  // Latch bytes from the read engine
  input  wire   [7:0]        latch0_i,
  input  wire   [7:0]        latch1_i,
  input  wire   [7:0]        latch2_i,
  input  wire   [7:0]        latch3_i,

  vga_cfg_if.wr              cfg,
  vga_sram_if.master         mem
);

  logic [1:0]        plane;
  logic              done;
  logic [CPU_AW-1:1] offset;
  logic              start;
  logic              last_ack;
  logic [7:0]        latch_b [NPLANES];
  logic [1:0]        wmode;
  logic [DW-1:0]     lat_rep;
  logic [DW-1:0]     mask_rep;
  logic [DW-1:0]     src;
  logic [DW-1:0]     wr_word;

  // Same folding as the read side
  assign offset = cfg.memory_mapping1 ? {1'b0, wbs_adr_i[CPU_AW-2:1]}
                                      : wbs_adr_i[CPU_AW-1:1];

  assign mem.adr   = {offset, plane};
  assign mem.dat_w = wr_word;
  assign mem.sel   = wbs_sel_i;
  assign mem.we    = 1'b1;

  assign start    = wr_stb_i && !mem.stb && !done;
  assign last_ack = mem.ack && mem.stb && (plane == 2'd3);
  assign wr_ack_o = last_ack;

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      mem.stb <= 1'b0;
      done    <= 1'b0;
      plane   <= 2'd0;
    end
    else
    begin
      if (start)
        mem.stb <= 1'b1;
      else if (last_ack)
        mem.stb <= 1'b0;

      // Hold off until the registered strobe has dropped
      if (last_ack)
        done <= 1'b1;
      else if (!wr_stb_i)
        done <= 1'b0;

      if (mem.ack && mem.stb)
        plane <= plane + 2'd1;
    end
  end

  assign latch_b[0] = latch0_i;
  assign latch_b[1] = latch1_i;
  assign latch_b[2] = latch2_i;
  assign latch_b[3] = latch3_i;

  // Fold mode 3 onto mode 0
  assign wmode = (cfg.write_mode == WM_LATCH || cfg.write_mode == WM_COLOR)
               ? cfg.write_mode : WM_SETRESET;

  // Per-plane data for the current plane
  always_comb
  begin
    lat_rep  = {2{latch_b[plane]}};
    mask_rep = {2{cfg.bit_mask}};
    case (wmode)
      WM_SETRESET: src = cfg.en_set_reset[plane] ? {DW{cfg.set_reset[plane]}}
                                                 : wbs_dat_i;
      WM_LATCH:    src = lat_rep;
      WM_COLOR:    src = {DW{wbs_dat_i[plane]}};
      default:     src = wbs_dat_i;
    endcase

    // Latch copy bypasses the bit mask
    if (wmode == WM_LATCH)
      wr_word = src;
    else
      wr_word = (src & mask_rep) | (lat_rep & ~mask_rep);
  end

endmodule

`default_nettype wire

// ==== logic/vga_sram_master.sv ====
// VGA SRAM master
// Picks the engine with a pending strobe, write first, and registers
// its request onto the SRAM bus. One gap cycle follows every ack so the
// engine can step to its next plane
`timescale 1ns/1ns
`default_nettype none

module vga_sram_master import vga_mem_pkg::*; (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,

  vga_sram_if.slave           rd,
  vga_sram_if.slave           wr,

  // SRAM Wishbone master
  output logic  [SRAM_AW:1]   sram_adr_o,
  output logic  [DW-1:0]      sram_dat_o,
  output logic  [1:0]         sram_sel_o,
  output logic                sram_we_o,
  output logic                sram_stb_o,
  input  wire   [DW-1:0]      sram_dat_i,
  input  wire                 sram_ack_i
);

  logic use_wr;  // engine owning the current word

  // Control, new request only while the bus is idle
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      sram_stb_o <= 1'b0;
      sram_we_o  <= 1'b0;
      use_wr     <= 1'b0;
    end
    else if (sram_stb_o)
    begin
      if (sram_ack_i)
        sram_stb_o <= 1'b0;
    end
    else
    begin
      sram_stb_o <= wr.stb || rd.stb;
      sram_we_o  <= wr.stb ? wr.we : rd.we;
      use_wr     <= wr.stb;
    end
  end

  // Payload, loaded alongside the strobe
  always_ff @(posedge wb_clk_i)
  begin
    if (!sram_stb_o)
    begin
      sram_adr_o <= wr.stb ? wr.adr   : rd.adr;
      sram_dat_o <= wr.stb ? wr.dat_w : rd.dat_w;
      sram_sel_o <= wr.stb ? wr.sel   : rd.sel;
    end
  end

  // Ack back to the owner only
  assign rd.ack   = sram_ack_i && sram_stb_o && !use_wr;
  assign wr.ack   = sram_ack_i && sram_stb_o && use_wr;
  assign rd.dat_r = sram_dat_i;
  assign wr.dat_r = sram_dat_i;

endmodule

`default_nettype wire

// ==== logic/vga_mem_top.sv ====
// VGA planar memory path, top level
// CPU Wishbone slave in, graphics-controller config port, Wishbone
// master out to the four-plane SRAM
`timescale 1ns/1ns
`default_nettype none

module vga_mem_top import vga_mem_pkg::*; (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,

  // CPU Wishbone slave
  input  wire   [CPU_AW:1]    wbs_adr_i,
  input  wire   [1:0]         wbs_sel_i,
  input  wire   [DW-1:0]      wbs_dat_i,
  input  wire                 wbs_we_i,
  input  wire                 wbs_stb_i,
  output logic  [DW-1:0]      wbs_dat_o,
  output logic                wbs_ack_o,

  // Graphics-controller config port
  input  wire                 cfg_we_i,
  input  wire   [3:0]         cfg_idx_i,
  input  wire   [7:0]         cfg_dat_i,

  // SRAM Wishbone master
  output logic  [SRAM_AW:1]   sram_adr_o,
  output logic  [DW-1:0]      sram_dat_o,
  output logic  [1:0]         sram_sel_o,
  output logic                sram_we_o,
  output logic                sram_stb_o,
  input  wire   [DW-1:0]      sram_dat_i,
  input  wire                 sram_ack_i
);

  logic          rd_stb;
  logic          wr_stb;
  logic          rd_ack;
  logic          wr_ack;
  logic [DW-1:0] rd_dat;
  logic [7:0]    latch0;
  logic [7:0]    latch1;
  logic [7:0]    latch2;
  logic [7:0]    latch3;

  vga_cfg_if  cfg_bus ();
  vga_sram_if rd_mem ();
  vga_sram_if wr_mem ();

  vga_gfx_regs regs_i (
    .wb_clk_i, .wb_rst_i, .cfg_we_i, .cfg_idx_i, .cfg_dat_i, .wbs_stb_i, .wbs_we_i,
    .rd_stb_o (rd_stb), .wr_stb_o (wr_stb), .cfg (cfg_bus.regs)
  );

  vga_read_iface read_i (
    .wb_clk_i, .wb_rst_i, .wbs_adr_i, .wbs_sel_i,
    .rd_stb_i (rd_stb), .rd_dat_o (rd_dat), .rd_ack_o (rd_ack),
    .latch0_o (latch0), .latch1_o (latch1), .latch2_o (latch2), .latch3_o (latch3),
    .cfg (cfg_bus.rd), .mem (rd_mem.master)
  );

  vga_write_iface write_i (
    .wb_clk_i, .wb_rst_i, .wbs_adr_i, .wbs_sel_i, .wbs_dat_i,
    .wr_stb_i (wr_stb), .wr_ack_o (wr_ack),
    .latch0_i (latch0), .latch1_i (latch1), .latch2_i (latch2), .latch3_i (latch3),
    .cfg (cfg_bus.wr), .mem (wr_mem.master)
  );

  vga_sram_master sram_i (
    .wb_clk_i, .wb_rst_i, .rd (rd_mem.slave), .wr (wr_mem.slave),
    .sram_adr_o, .sram_dat_o, .sram_sel_o, .sram_we_o, .sram_stb_o,
    .sram_dat_i, .sram_ack_i
  );

  // Only one engine runs at a time
  assign wbs_ack_o = rd_ack | wr_ack;
  assign wbs_dat_o = rd_dat;

endmodule

`default_nettype wire

// ==== test/vga_sram_model.sv ====
// Behavioral four-plane SRAM for the VGA memory path testbench
// Wishbone slave with a random ack latency of 1 to 3 cycles,
// byte-lane writes, and backdoor peek and poke for the checker
`timescale 1ns/1ns
`default_nettype none

module vga_sram_model import vga_mem_pkg::*; (
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,
  input  wire  [SRAM_AW:1]   adr_i,
  input  wire  [DW-1:0]      dat_i,
  input  wire  [1:0]         sel_i,
  input  wire                we_i,
  input  wire                stb_i,
  output logic [DW-1:0]      dat_o,
  output logic               ack_o
);

  logic [DW-1:0] mem [2**SRAM_AW];
  logic          busy;
  logic [1:0]    wait_cnt;

  // Power-up contents, every address bit takes part
  initial
  begin
    for (int i = 0; i < 2**SRAM_AW; i++)
      mem[i[SRAM_AW-1:0]] = 16'(i * 40503) ^ 16'(i >> 16);
  end

  always @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      ack_o    <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
    end
    else
    begin
      ack_o <= 1'b0;
      if (stb_i && !ack_o)
      begin
        // First cycle of a request picks the extra wait
        if (!busy)
        begin
          busy     <= 1'b1;
          wait_cnt <= 2'($urandom_range(2, 0));
        end
        else if (wait_cnt != 2'd0)
          wait_cnt <= wait_cnt - 2'd1;
        else
        begin
          busy  <= 1'b0;
          ack_o <= 1'b1;
          dat_o <= mem[adr_i];
          if (we_i && sel_i[0])
            mem[adr_i][7:0] = dat_i[7:0];
          if (we_i && sel_i[1])
            mem[adr_i][15:8] = dat_i[15:8];
        end
      end
    end
  end

  // Backdoor access, word index is {offset, plane}
  function automatic logic [DW-1:0] peek(input int idx);
    return mem[idx[SRAM_AW-1:0]];
  endfunction

  task automatic poke(input int idx, input logic [DW-1:0] val);
    mem[idx[SRAM_AW-1:0]] = val;
  endtask

endmodule

`default_nettype wire

// ==== test/tb_vga_mem.sv ====
// Testbench for the VGA planar memory path
// Runs read modes 0 and 1, write modes 0 to 2 and address folding
// against a reference of the four planes, latches and registers
`timescale 1ns/1ns
`default_nettype none

module tb_vga_mem import vga_mem_pkg::*;;

  localparam int CLK_PERIOD     = 40;
  localparam int MAX_ACCESSES   = 200;
  localparam int TIMEOUT_CYCLES = MAX_ACCESSES * NPLANES * 8;

  logic              wb_clk_i;
  logic              wb_rst_i;
  logic [CPU_AW:1]   wbs_adr_i;
  logic [1:0]        wbs_sel_i;
  logic [DW-1:0]     wbs_dat_i;
  logic              wbs_we_i;
  logic              wbs_stb_i;
  logic [DW-1:0]     wbs_dat_o;
  logic              wbs_ack_o;
  logic              cfg_we_i;
  logic [3:0]        cfg_idx_i;
  logic [7:0]        cfg_dat_i;
  logic [SRAM_AW:1]  sram_adr;
  logic [DW-1:0]     sram_dat_w;
  logic [1:0]        sram_sel;
  logic              sram_we;
  logic              sram_stb;
  logic [DW-1:0]     sram_dat_r;
  logic              sram_ack;

  // Reference state: plane words, latches, register copies
  logic [DW-1:0]      ref_mem [int];
  logic [DW-1:0]      r_latch [NPLANES];
  logic               r_lsel;
  logic [NPLANES-1:0] r_sr;
  logic [NPLANES-1:0] r_en_sr;
  logic [NPLANES-1:0] r_cc;
  logic [NPLANES-1:0] r_dc;
  logic [1:0]         r_rms;
  logic               r_rmode;
  logic [1:0]         r_wmode;
  logic               r_map1;
  logic [7:0]         r_mask;

  // Expected results, in access order
  bit                 kind_q [$];   // 1 read, 0 write
  logic [DW-1:0]      exp_rd_q [$];
  int                 exp_idx_q [$];
  logic [DW-1:0]      exp_val_q [$];

  int checks;
  int errors;
  int cycle_cnt;

  vga_mem_top dut_i (
    .wb_clk_i, .wb_rst_i, .wbs_adr_i, .wbs_sel_i, .wbs_dat_i, .wbs_we_i, .wbs_stb_i,
    .wbs_dat_o, .wbs_ack_o, .cfg_we_i, .cfg_idx_i, .cfg_dat_i,
    .sram_adr_o (sram_adr), .sram_dat_o (sram_dat_w), .sram_sel_o (sram_sel),
    .sram_we_o (sram_we), .sram_stb_o (sram_stb), .sram_dat_i (sram_dat_r),
    .sram_ack_i (sram_ack)
  );

  vga_sram_model sram_i (
    .wb_clk_i, .wb_rst_i, .adr_i (sram_adr), .dat_i (sram_dat_w), .sel_i (sram_sel),
    .we_i (sram_we), .stb_i (sram_stb), .dat_o (sram_dat_r), .ack_o (sram_ack)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  // CPU offset, bit 15 ignored with mapping1
  function automatic logic [CPU_AW-1:1] fold_offset(input logic [CPU_AW:1] adr);
    logic [CPU_AW-1:1] off;
    off = adr[CPU_AW-1:1];
    if (r_map1)
      off[CPU_AW-1] = 1'b0;
    return off;
  endfunction

  function automatic int word_index(input logic [CPU_AW-1:1] off, input int p);
    return int'({off, p[1:0]});
  endfunction

  // Read data: one plane, or inverted OR of cared-for differences
  function automatic logic [DW-1:0] expect_read(input logic [CPU_AW-1:1] off);
    logic [DW-1:0] diff;
    logic [DW-1:0] w;
    diff = '0;
    if (!r_rmode)
      return ref_mem[word_index(off, int'(r_rms))];
    for (int p = 0; p < NPLANES; p++)
    begin
      w = ref_mem[word_index(off, p)];
      if (r_dc[p[1:0]])
        diff = diff | (w ^ {DW{r_cc[p[1:0]]}});
    end
    return ~diff;
  endfunction

  // New plane word after a write, merged under the byte lanes
  function automatic logic [DW-1:0] expect_plane(input int p, input logic [DW-1:0] old,
                                                 input logic [DW-1:0] dat,
                                                 input logic [1:0] sel);
    logic [7:0]    lb;
    logic [DW-1:0] lat;
    logic [DW-1:0] mask;
    logic [DW-1:0] src;
    logic [DW-1:0] nw;
    lb   = r_lsel ? r_latch[p[1:0]][15:8] : r_latch[p[1:0]][7:0];
    lat  = {lb, lb};
    mask = {r_mask, r_mask};
    if (r_wmode == WM_LATCH)
      nw = lat;
    else
    begin
      if (r_wmode == WM_COLOR)
        src = {DW{dat[p[3:0]]}};
      else if (r_en_sr[p[1:0]])
        src = {DW{r_sr[p[1:0]]}};
      else
        src = dat;
      nw = (src & mask) | (lat & ~mask);
    end
    return {sel[1] ? nw[15:8] : old[15:8], sel[0] ? nw[7:0] : old[7:0]};
  endfunction

  task automatic check_rd_data(input logic [DW-1:0] exp, input logic [DW-1:0] got);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: read data expected %h, got %h", $time, exp, got);
    end
  endtask

  task automatic check_plane_word(input int idx, input logic [DW-1:0] exp);
    logic [DW-1:0] got;
    got = sram_i.peek(idx);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: SRAM word %h expected %h, got %h", $time, idx, exp, got);
    end
  endtask

  task automatic report_counts();
    $display("Checks: %0d, errors: %0d", checks, errors);
  endtask

  // Config port write, reference copy follows
  task automatic write_reg(input logic [3:0] idx, input logic [7:0] dat);
    @(negedge wb_clk_i);
    cfg_we_i  = 1'b1;
    cfg_idx_i = idx;
    cfg_dat_i = dat;
    @(negedge wb_clk_i);
    cfg_we_i = 1'b0;
    case (idx)
      GR_SET_RESET:    r_sr    = dat[NPLANES-1:0];
      GR_EN_SET_RESET: r_en_sr = dat[NPLANES-1:0];
      GR_COLOR_CMP:    r_cc    = dat[NPLANES-1:0];
      GR_READ_MAP:     r_rms   = dat[1:0];
      GR_MODE:
      begin
        r_wmode = dat[WMODE_LSB +: 2];
        r_rmode = dat[RMODE_BIT];
      end
      GR_MISC:         r_map1  = dat[MISC_MAP_BIT];
      GR_DONT_CARE:    r_dc    = dat[NPLANES-1:0];
      GR_BIT_MASK:     r_mask  = dat;
      default:         ;
    endcase
  endtask

  task automatic set_mode(input logic rmode, input logic [1:0] wmode);
    logic [7:0] dat;
    dat = '0;
    dat[WMODE_LSB +: 2] = wmode;
    dat[RMODE_BIT] = rmode;
    write_reg(GR_MODE, dat);
  endtask

  // First touch of an offset gets random plane words
  task automatic fill_offset(input logic [CPU_AW-1:1] off);
    int            idx;
    logic [DW-1:0] w;
    for (int p = 0; p < NPLANES; p++)
    begin
      idx = word_index(off, p);
      if (!ref_mem.exists(idx))
      begin
        w = 16'($urandom);
        ref_mem[idx] = w;
        sram_i.poke(idx, w);
      end
    end
  endtask

  // CPU strobe held until ack
  task automatic bus_access(input logic [CPU_AW:1] adr, input logic [1:0] sel,
                            input logic [DW-1:0] dat, input logic we);
    @(negedge wb_clk_i);
    wbs_adr_i = adr;
    wbs_sel_i = sel;
    wbs_dat_i = dat;
    wbs_we_i  = we;
    wbs_stb_i = 1'b1;
    @(negedge wb_clk_i);
    while (!wbs_ack_o)
      @(negedge wb_clk_i);
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic cpu_read(input logic [CPU_AW:1] adr, input logic [1:0] sel);
    logic [CPU_AW-1:1] off;
    off = fold_offset(adr);
    fill_offset(off);
    exp_rd_q.push_back(expect_read(off));
    kind_q.push_back(1'b1);
    // Every read reloads all four latches
    for (int p = 0; p < NPLANES; p++)
      r_latch[p] = ref_mem[word_index(off, p)];
    r_lsel = sel[1];
    bus_access(adr, sel, '0, 1'b0);
  endtask

  task automatic cpu_write(input logic [CPU_AW:1] adr, input logic [1:0] sel,
                           input logic [DW-1:0] dat);
    logic [CPU_AW-1:1] off;
    int                idx;
    logic [DW-1:0]     w;
    off = fold_offset(adr);
    fill_offset(off);
    for (int p = 0; p < NPLANES; p++)
    begin
      idx = word_index(off, p);
      w = expect_plane(p, ref_mem[idx], dat, sel);
      ref_mem[idx] = w;
      exp_idx_q.push_back(idx);
      exp_val_q.push_back(w);
    end
    kind_q.push_back(1'b0);
    bus_access(adr, sel, dat, 1'b1);
  endtask

  function automatic logic [CPU_AW:1] rand_adr();
    return {1'b0, 15'($urandom)};
  endfunction

  function automatic logic [1:0] rand_sel();
    return 2'($urandom_range(3, 1));
  endfunction

  // Compares each completed access, all plane words settled by now
  always @(negedge wb_clk_i)
  begin
    if (!wb_rst_i && wbs_ack_o)
    begin
      if (kind_q.size() == 0)
      begin
        errors++;
        $display("Error at %0t ns: acknowledge with no access outstanding", $time);
      end
      else if (kind_q.pop_front())
        check_rd_data(exp_rd_q.pop_front(), wbs_dat_o);
      else
      begin
        for (int p = 0; p < NPLANES; p++)
          check_plane_word(exp_idx_q.pop_front(), exp_val_q.pop_front());
      end
    end
  end

  always @(posedge wb_clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      report_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [CPU_AW:1] adr;
    logic [1:0]      sel;
    void'($urandom(32'ha313));
    wb_clk_i  = 1'b0;
    wb_rst_i  = 1'b1;
    wbs_adr_i = '0;
    wbs_sel_i = 2'b00;
    wbs_dat_i = '0;
    wbs_we_i  = 1'b0;
    wbs_stb_i = 1'b0;
    cfg_we_i  = 1'b0;
    cfg_idx_i = 4'd0;
    cfg_dat_i = 8'd0;
    checks    = 0;
    errors    = 0;
    cycle_cnt = 0;
    r_lsel    = 1'b0;
    r_sr      = '0;
    r_en_sr   = '0;
    r_cc      = '0;
    r_dc      = '0;
    r_rms     = 2'd0;
    r_rmode   = 1'b0;
    r_wmode   = WM_SETRESET;
    r_map1    = 1'b0;
    r_mask    = 8'd0;
    for (int p = 0; p < NPLANES; p++)
      r_latch[p] = '0;
    repeat (3) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    // Read mode 0, each plane select
    set_mode(1'b0, WM_SETRESET);
    for (int m = 0; m < NPLANES; m++)
    begin
      write_reg(GR_READ_MAP, 8'(m));
      repeat (8) cpu_read(rand_adr(), rand_sel());
    end

    // Read mode 1, colour compare
    set_mode(1'b1, WM_SETRESET);
    repeat (20)
    begin
      write_reg(GR_COLOR_CMP, 8'($urandom_range(15, 0)));
      write_reg(GR_DONT_CARE, 8'($urandom_range(15, 0)));
      cpu_read(rand_adr(), rand_sel());
    end

    // Write mode 0, latches from a read of the same lane
    set_mode(1'b0, WM_SETRESET);
    repeat (15)
    begin
      adr = rand_adr();
      sel = rand_sel();
      write_reg(GR_SET_RESET, 8'($urandom_range(15, 0)));
      write_reg(GR_EN_SET_RESET, 8'($urandom_range(15, 0)));
      write_reg(GR_BIT_MASK, 8'($urandom));
      cpu_read(adr, sel);
      cpu_write(adr, sel, 16'($urandom));
    end

    // Write mode 1, latch copy from A to B
    set_mode(1'b0, WM_LATCH);
    repeat (10)
    begin
      sel = rand_sel();
      cpu_read(rand_adr(), sel);
      cpu_write(rand_adr(), sel, 16'($urandom));
    end

    // Write mode 2, colour expansion
    set_mode(1'b0, WM_COLOR);
    repeat (10)
    begin
      adr = rand_adr();
      sel = rand_sel();
      write_reg(GR_BIT_MASK, 8'($urandom));
      cpu_read(adr, sel);
      cpu_write(adr, sel, 16'($urandom));
    end

    // Mapping1, bit 15 aliases for reads and writes
    write_reg(GR_MISC, 8'(1 << MISC_MAP_BIT));
    repeat (8)
    begin
      adr = rand_adr();
      adr[CPU_AW-1] = 1'b1;
      sel = rand_sel();
      write_reg(GR_READ_MAP, 8'($urandom_range(3, 0)));
      write_reg(GR_BIT_MASK, 8'($urandom));
      cpu_read(adr, sel);
      cpu_write(adr, sel, 16'($urandom));
      adr[CPU_AW-1] = 1'b0;
      cpu_read(adr, sel);
    end

    repeat (4) @(negedge wb_clk_i);
    if (kind_q.size() != 0)
    begin
      errors++;
      $display("Error: %0d accesses were never acknowledged", kind_q.size());
    end
    report_counts();
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/vga_mem_pkg.sv
logic/vga_mem_ifs.sv
logic/vga_gfx_regs.sv
logic/vga_read_iface.sv
logic/vga_write_iface.sv
logic/vga_sram_master.sv
logic/vga_mem_top.sv
test/vga_sram_model.sv
test/tb_vga_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the VGA memory path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -j 0 \
  --top-module tb_vga_mem --Mdir obj_dir -o vtb_vga_mem -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vtb_vga_mem > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
